// File: dv/pwo_stimulus.txt
# columns: name mode(mul add sub) accumulate a b c expected
# decimal coefficients of lane 0 word 0, other slots add lane plus word
mul_small   mul 0 3       5       7       15
mul_wrap    mul 0 8380416 2       11      8380415
mul_large   mul 0 4194304 4       0       16382
mac_small   mul 1 100     200     300     20300
mac_wrap    mul 1 8380416 8380416 8380416 0
add_small   add 0 10      20      5       30
add_wrap    add 0 8000000 1000000 0       619583
add_acc_off add 1 1       2       99      3
sub_pos     sub 0 500     200     0       300
sub_neg     sub 0 200     500     0       8380117

// File: project.f
rtl/pwo_pkg.sv
rtl/pwo_addr_gen.sv
rtl/pwo_operand_unpack.sv
rtl/pwo_lane.sv
rtl/pwo_result_pack.sv
rtl/pwo_top.sv
dv/pwo_clk_gen.sv
dv/pwo_sva.sv
dv/pwo_tb.sv

// File: dv/pwo_tb.sv
/*
 * Pointwise operation engine testbench
 * Memory models for a, b and c, tests read from the stimulus file,
 * per-write timing and value checks, and a watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module pwo_tb
    import pwo_pkg::*;
();

    localparam int        CLK_PERIOD   = 100;
    localparam int        RESET_CYCLES = 5;
    localparam int        MAX_TESTS    = 16;
    localparam int        DONE_TIMEOUT = 200;
    // Word k is written in cycle k + 6, done follows the last write
    localparam int        WR_OFFSET    = 6;
    localparam int        DONE_CYCLE   = POLY_WORDS + WR_OFFSET;
    localparam mem_addr_t BASE_A       = 15'h0100;
    localparam mem_addr_t BASE_B       = 15'h0200;
    localparam mem_addr_t BASE_C       = 15'h7fc0;

    logic      clk;
    logic      reset_n;
    logic      start_i;
    pwo_mode_e mode_i;
    logic      accumulate_i;
    mem_addr_t base_a_i;
    mem_addr_t base_b_i;
    mem_addr_t base_c_i;
    logic      rd_en_a_o;
    logic      rd_en_b_o;
    logic      rd_en_c_o;
    mem_addr_t rd_addr_a_o;
    mem_addr_t rd_addr_b_o;
    mem_addr_t rd_addr_c_o;
    mem_word_t rd_data_a_i;
    mem_word_t rd_data_b_i;
    mem_word_t rd_data_c_i;
    logic      wr_en_o;
    mem_addr_t wr_addr_o;
    mem_word_t wr_data_o;
    logic      busy_o;
    logic      done_o;

    // Memory models, indexed by word within the polynomial
    mem_word_t mem_a [POLY_WORDS];
    mem_word_t mem_b [POLY_WORDS];
    mem_word_t mem_c [POLY_WORDS];
    coeff_t    exp_coeff [POLY_WORDS][COEFFS_PER_WORD];
    mem_addr_t idx_a;
    mem_addr_t idx_b;
    mem_addr_t idx_c;
    mem_addr_t idx_w;

    // Test table loaded from the stimulus file
    logic [8*16-1:0] t_name [MAX_TESTS];
    pwo_mode_e       t_mode [MAX_TESTS];
    bit              t_acc  [MAX_TESTS];
    int              t_a    [MAX_TESTS];
    int              t_b    [MAX_TESTS];
    int              t_c    [MAX_TESTS];
    int              t_exp  [MAX_TESTS];
    int              num_tests = 0;
    bit              tests_loaded = 0;

    logic [8*16-1:0] cur_name;
    bit              checking = 0;
    int              cyc = 1000;
    int              wk;
    int              wr_count;
    int              rdc_count;
    int              done_count;
    int              error_count = 0;
    int              passed = 0;

    pwo_clk_gen pwo_clk_gen_i (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    pwo_top pwo_top_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .base_a_i     (base_a_i),
        .base_b_i     (base_b_i),
        .base_c_i     (base_c_i),
        .rd_en_a_o    (rd_en_a_o),
        .rd_en_b_o    (rd_en_b_o),
        .rd_en_c_o    (rd_en_c_o),
        .rd_addr_a_o  (rd_addr_a_o),
        .rd_addr_b_o  (rd_addr_b_o),
        .rd_addr_c_o  (rd_addr_c_o),
        .rd_data_a_i  (rd_data_a_i),
        .rd_data_b_i  (rd_data_b_i),
        .rd_data_c_i  (rd_data_c_i),
        .wr_en_o      (wr_en_o),
        .wr_addr_o    (wr_addr_o),
        .wr_data_o    (wr_data_o),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    // ====================================================================
    // Reporting and reference model
    // ====================================================================

    task automatic mismatch_error(input string what, input logic [MEM_DATA_WIDTH-1:0] exp,
                                  input logic [MEM_DATA_WIDTH-1:0] act);
        $display("** Error: %0s: %0s expected %0d actual %0d", cur_name, what, exp, act);
        error_count++;
    endtask

    task automatic note_failure(input string msg);
        $display("Error in %0s: %0s", cur_name, msg);
        error_count++;
    endtask

    function automatic coeff_t expected_coeff(input pwo_mode_e mode, input bit acc,
                                              input coeff_t a, input coeff_t b, input coeff_t c);
        longint unsigned q;
        longint unsigned r;
        q = PWO_Q;
        case (mode)
            PWO_MUL: r = (longint'(a) * longint'(b) + (acc ? longint'(c) : 0)) % q;
            PWO_ADD: r = (longint'(a) + longint'(b)) % q;
            default: r = (longint'(a) + q - longint'(b)) % q;
        endcase
        return coeff_t'(r);
    endfunction

    // ====================================================================
    // Memory models and monitor
    // ====================================================================

    always @(posedge clk) begin
        idx_a = rd_addr_a_o - BASE_A;
        idx_b = rd_addr_b_o - BASE_B;
        idx_c = rd_addr_c_o - BASE_C;
        idx_w = wr_addr_o - BASE_C;
        // Read data holds junk except in the cycle after a strobe
        rd_data_a_i <= '1;
        rd_data_b_i <= '1;
        rd_data_c_i <= '1;
        if (rd_en_a_o && idx_a < POLY_WORDS) rd_data_a_i <= mem_a[idx_a];
        else if (rd_en_a_o) note_failure("read of memory a outside the polynomial");
        if (rd_en_b_o && idx_b < POLY_WORDS) rd_data_b_i <= mem_b[idx_b];
        else if (rd_en_b_o) note_failure("read of memory b outside the polynomial");
        if (rd_en_c_o && idx_c < POLY_WORDS) rd_data_c_i <= mem_c[idx_c];
        else if (rd_en_c_o) note_failure("read of memory c outside the polynomial");
        if (wr_en_o && idx_w < POLY_WORDS) mem_c[idx_w] <= wr_data_o;
    end

    always @(posedge clk) begin
        // Cycle 0 is the edge that takes the start
        if (start_i && !busy_o) cyc = 0;
        else cyc = cyc + 1;
        if (checking) begin
            if (busy_o !== (cyc >= 1 && cyc <= DONE_CYCLE))
                mismatch_error($sformatf("busy_o in cycle %0d", cyc),
                               (cyc >= 1 && cyc <= DONE_CYCLE), busy_o);
            if (rd_en_c_o) rdc_count++;
            if (done_o) begin
                done_count++;
                if (cyc != DONE_CYCLE) mismatch_error("done_o cycle", DONE_CYCLE, cyc);
            end
            if (wr_en_o) begin
                wr_count++;
                wk = cyc - WR_OFFSET;
                if (wk < 0 || wk >= POLY_WORDS) begin
                    note_failure($sformatf("write in cycle %0d outside the expected window", cyc));
                end else begin
                    if (wr_addr_o !== BASE_C + wk)
                        mismatch_error($sformatf("address of word %0d", wk), BASE_C + wk,
                                       wr_addr_o);
                    for (int i = 0; i < COEFFS_PER_WORD; i++) begin
                        if (wr_data_o[i*SLOT_WIDTH +: SLOT_WIDTH] !== {1'b0, exp_coeff[wk][i]})
                            mismatch_error($sformatf("word %0d lane %0d", wk, i),
                                           exp_coeff[wk][i],
                                           wr_data_o[i*SLOT_WIDTH +: SLOT_WIDTH]);
                    end
                end
            end
        end
    end

    // ====================================================================
    // Test flow
    // ====================================================================

    task automatic load_tests;
        int              fd;
        int              r;
        logic [8*16-1:0] tok;
        logic [8*80-1:0] line;
        logic [8*4-1:0]  mode_str;
        int              acc;
        int              a;
        int              b;
        int              c;
        int              e;
        fd = $fopen("dv/pwo_stimulus.txt", "r");
        if (fd == 0) begin
            note_failure("cannot open the stimulus file dv/pwo_stimulus.txt");
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1) break;
            if (tok == "#") begin
                // Comment line
                r = $fgets(line, fd);
            end else begin
                r = $fscanf(fd, "%s %d %d %d %d %d", mode_str, acc, a, b, c, e);
                if (r != 6) begin
                    note_failure("malformed line in the stimulus file");
                    break;
                end
                t_name[num_tests] = tok;
                t_acc[num_tests]  = (acc != 0);
                t_a[num_tests]    = a;
                t_b[num_tests]    = b;
                t_c[num_tests]    = c;
                t_exp[num_tests]  = e;
                if (mode_str == "mul") t_mode[num_tests] = PWO_MUL;
                else if (mode_str == "add") t_mode[num_tests] = PWO_ADD;
                else if (mode_str == "sub") t_mode[num_tests] = PWO_SUB;
                else note_failure("unknown mode in the stimulus file");
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic fill_memories(input int n);
        coeff_t a;
        coeff_t b;
        coeff_t c;
        for (int k = 0; k < POLY_WORDS; k++) begin
            for (int i = 0; i < COEFFS_PER_WORD; i++) begin
                // Lane i of word k holds the base coefficient plus i plus k
                a = coeff_t'((longint'(t_a[n]) + i + k) % PWO_Q);
                b = coeff_t'((longint'(t_b[n]) + i + k) % PWO_Q);
                c = coeff_t'((longint'(t_c[n]) + i + k) % PWO_Q);
                mem_a[k][i*SLOT_WIDTH +: SLOT_WIDTH] = {1'b0, a};
                mem_b[k][i*SLOT_WIDTH +: SLOT_WIDTH] = {1'b0, b};
                mem_c[k][i*SLOT_WIDTH +: SLOT_WIDTH] = {1'b0, c};
                exp_coeff[k][i] = expected_coeff(t_mode[n], t_acc[n], a, b, c);
            end
        end
        if (exp_coeff[0][0] != t_exp[n])
            mismatch_error("base expectation", t_exp[n], exp_coeff[0][0]);
    endtask

    task automatic run_test(input int n);
        int waited;
        int errs_before;
        bit seen_done;
        cur_name = t_name[n];
        errs_before = error_count + pwo_top_i.pwo_sva_i.fail_count;
        fill_memories(n);
        wr_count = 0;
        rdc_count = 0;
        done_count = 0;
        @(posedge clk);
        #1;
        mode_i = t_mode[n];
        accumulate_i = t_acc[n];
        start_i = 1'b1;
        checking = 1'b1;
        @(posedge clk);
        #1 start_i = 1'b0;
        // Second start after the last read, while still busy, must be ignored
        repeat (POLY_WORDS + 1) @(posedge clk);
        #1 start_i = 1'b1;
        @(posedge clk);
        #1 start_i = 1'b0;
        waited = 0;
        seen_done = 1'b0;
        while (!seen_done && waited < DONE_TIMEOUT) begin
            @(posedge clk);
            seen_done = done_o;
            waited++;
        end
        if (!seen_done) note_failure("done_o never pulsed");
        repeat (4) @(posedge clk);
        #1 checking = 1'b0;

        if (wr_count != POLY_WORDS) mismatch_error("write count", POLY_WORDS, wr_count);
        if (done_count != 1) mismatch_error("done pulse count", 1, done_count);
        if (rdc_count != ((t_mode[n] == PWO_MUL && t_acc[n]) ? POLY_WORDS : 0))
            mismatch_error("rd_en_c_o count",
                           (t_mode[n] == PWO_MUL && t_acc[n]) ? POLY_WORDS : 0, rdc_count);
        for (int k = 0; k < POLY_WORDS; k++) begin
            for (int i = 0; i < COEFFS_PER_WORD; i++) begin
                if (mem_c[k][i*SLOT_WIDTH +: SLOT_WIDTH] !== {1'b0, exp_coeff[k][i]})
                    mismatch_error($sformatf("final memory c word %0d lane %0d", k, i),
                                   exp_coeff[k][i], mem_c[k][i*SLOT_WIDTH +: SLOT_WIDTH]);
            end
        end

        if (error_count + pwo_top_i.pwo_sva_i.fail_count == errs_before) begin
            passed++;
            $display("PASS %0s", cur_name);
        end else begin
            $display("FAIL %0s (%0d errors)", cur_name,
                     error_count + pwo_top_i.pwo_sva_i.fail_count - errs_before);
        end
    endtask

    initial begin
        start_i      = 1'b0;
        mode_i       = PWO_MUL;
        accumulate_i = 1'b0;
        base_a_i     = BASE_A;
        base_b_i     = BASE_B;
        base_c_i     = BASE_C;
        rd_data_a_i  = '0;
        rd_data_b_i  = '0;
        rd_data_c_i  = '0;
        cur_name     = "setup";
        @(posedge reset_n);
        load_tests();
        tests_loaded = 1'b1;
        if (num_tests == 0) note_failure("no tests were read from the stimulus file");
        for (int n = 0; n < num_tests; n++) begin
            run_test(n);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors, %0d assertion failures",
                 num_tests, passed, num_tests - passed, error_count,
                 pwo_top_i.pwo_sva_i.fail_count);
        if (error_count == 0 && pwo_top_i.pwo_sva_i.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the number of tests
    initial begin
        wait (tests_loaded);
        #(num_tests * 100 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/pwo_sva.sv
/*
 * Concurrent assertions on the engine top-level ports
 * Bound into every pwo_top instance
 */

`timescale 1ns/1ps
`default_nettype none

module pwo_sva
    import pwo_pkg::*;
(
    input logic      clk,
    input logic      reset_n,
    input logic      done_i,
    input logic      wr_en_i,
    input logic      busy_i,
    input logic      rd_en_c_i,
    input pwo_mode_e mode_i,
    input logic      accumulate_i
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    a_done_single: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |=> !done_i)
        else begin
            $error("done_o stayed high for more than one cycle");
            fail_count++;
        end

    a_write_in_busy: assert property (@(posedge clk) disable iff (!reset_n)
        wr_en_i |-> busy_i)
        else begin
            $error("wr_en_o high while busy_o is low");
            fail_count++;
        end

    // Accumulator reads belong to multiply-accumulate only
    a_c_read_mac: assert property (@(posedge clk) disable iff (!reset_n)
        rd_en_c_i |-> (mode_i == PWO_MUL) && accumulate_i)
        else begin
            $error("rd_en_c_o strobed outside multiply-accumulate");
            fail_count++;
        end

endmodule

bind pwo_top pwo_sva pwo_sva_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .done_i       (done_o),
    .wr_en_i      (wr_en_o),
    .busy_i       (busy_o),
    .rd_en_c_i    (rd_en_c_o),
    .mode_i       (mode_i),
    .accumulate_i (accumulate_i)
);

`default_nettype wire

// File: dv/pwo_clk_gen.sv
/*
 * Testbench clock and reset generator
 * 100 ns clock, active-low reset held for the first five cycles
 */

`timescale 1ns/1ps
`default_nettype none

module pwo_clk_gen (
    output logic clk_o,
    output logic reset_n_o
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        // Release away from the edge
        #1 reset_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: rtl/pwo_top.sv
/*
 * Pointwise operation engine top level
 * Multiply(-accumulate), add and subtract over 64-word polynomials
 * with four modular lanes per memory word
 */

`timescale 1ns/1ps
`default_nettype none

module pwo_top
    import pwo_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      start_i,
    input  pwo_mode_e mode_i,
    input  logic      accumulate_i,
    input  mem_addr_t base_a_i,
    input  mem_addr_t base_b_i,
    input  mem_addr_t base_c_i,
    output logic      rd_en_a_o,
    output logic      rd_en_b_o,
    output logic      rd_en_c_o,
    output mem_addr_t rd_addr_a_o,
    output mem_addr_t rd_addr_b_o,
    output mem_addr_t rd_addr_c_o,
    input  mem_word_t rd_data_a_i,
    input  mem_word_t rd_data_b_i,
    input  mem_word_t rd_data_c_i,
    output logic      wr_en_o,
    output mem_addr_t wr_addr_o,
    output mem_word_t wr_data_o,
    output logic      busy_o,
    output logic      done_o
);

    // Address generator to unpacker
    logic                         issue;
    logic                         issue_last;
    mem_addr_t                    issue_addr;

    // Unpacker to lanes and packer
    coeff_t [COEFFS_PER_WORD-1:0] coeff_a;
    coeff_t [COEFFS_PER_WORD-1:0] coeff_b;
    coeff_t [COEFFS_PER_WORD-1:0] coeff_c;
    logic                         mul_mode;
    logic                         sub_mode;
    logic                         op_valid;
    logic                         op_last;
    mem_addr_t                    op_addr;

    coeff_t [COEFFS_PER_WORD-1:0] lane_result;

    pwo_addr_gen pwo_addr_gen_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .base_a_i     (base_a_i),
        .base_b_i     (base_b_i),
        .base_c_i     (base_c_i),
        .rd_en_a_o    (rd_en_a_o),
        .rd_en_b_o    (rd_en_b_o),
        .rd_en_c_o    (rd_en_c_o),
        .rd_addr_a_o  (rd_addr_a_o),
        .rd_addr_b_o  (rd_addr_b_o),
        .rd_addr_c_o  (rd_addr_c_o),
        .issue_o      (issue),
        .issue_last_o (issue_last),
        .issue_addr_o (issue_addr),
        .busy_o       (busy_o),
        .done_i       (done_o)
    );

    pwo_operand_unpack pwo_operand_unpack_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .issue_i      (issue),
        .issue_last_i (issue_last),
        .issue_addr_i (issue_addr),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .rd_data_a_i  (rd_data_a_i),
        .rd_data_b_i  (rd_data_b_i),
        .rd_data_c_i  (rd_data_c_i),
        .coeff_a_o    (coeff_a),
        .coeff_b_o    (coeff_b),
        .coeff_c_o    (coeff_c),
        .mul_mode_o   (mul_mode),
        .sub_mode_o   (sub_mode),
        .op_valid_o   (op_valid),
        .op_last_o    (op_last),
        .op_addr_o    (op_addr)
    );

    // One lane per coefficient slot
    for (genvar g = 0; g < COEFFS_PER_WORD; g++) begin : g_lane
        pwo_lane pwo_lane_i (
            .clk        (clk),
            .reset_n    (reset_n),
            .a_i        (coeff_a[g]),
            .b_i        (coeff_b[g]),
            .c_i        (coeff_c[g]),
            .mul_mode_i (mul_mode),
            .sub_mode_i (sub_mode),
            .result_o   (lane_result[g])
        );
    end

    pwo_result_pack pwo_result_pack_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .op_valid_i (op_valid),
        .op_last_i  (op_last),
        .op_addr_i  (op_addr),
        .result_i   (lane_result),
        .wr_en_o    (wr_en_o),
        .wr_addr_o  (wr_addr_o),
        .wr_data_o  (wr_data_o),
        .done_o     (done_o)
    );

endmodule

`default_nettype wire

// File: rtl/pwo_result_pack.sv
/*
 * Result packer
 * Carries the word tags past the lanes, packs four results into a memory
 * word and drives the write port and the done pulse
 */

`timescale 1ns/1ps
`default_nettype none

module pwo_result_pack
    import pwo_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         op_valid_i,
    input  logic                         op_last_i,
    input  mem_addr_t                    op_addr_i,
    input  coeff_t [COEFFS_PER_WORD-1:0] result_i,
    output logic                         wr_en_o,
    output mem_addr_t                    wr_addr_o,
    output mem_word_t                    wr_data_o,
    output logic                         done_o
);

    logic      valid_d [LANE_LATENCY];
    logic      last_d  [LANE_LATENCY];
    mem_addr_t addr_d  [LANE_LATENCY];
    logic      wr_last_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < LANE_LATENCY; i++) begin
                valid_d[i] <= 1'b0;
                last_d[i]  <= 1'b0;
            end
            wr_en_o   <= 1'b0;
            wr_last_q <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            valid_d[0] <= op_valid_i;
            last_d[0]  <= op_last_i;
            for (int i = 1; i < LANE_LATENCY; i++) begin
                valid_d[i] <= valid_d[i-1];
                last_d[i]  <= last_d[i-1];
            end
            wr_en_o   <= valid_d[LANE_LATENCY-1];
            wr_last_q <= valid_d[LANE_LATENCY-1] && last_d[LANE_LATENCY-1];
            // One cycle after the final write
            done_o    <= wr_en_o && wr_last_q;
        end
    end

    always_ff @(posedge clk) begin
        addr_d[0] <= op_addr_i;
        for (int i = 1; i < LANE_LATENCY; i++) begin
            addr_d[i] <= addr_d[i-1];
        end
        wr_addr_o <= addr_d[LANE_LATENCY-1];
        for (int i = 0; i < COEFFS_PER_WORD; i++) begin
            wr_data_o[i*SLOT_WIDTH +: SLOT_WIDTH] <=
                {{(SLOT_WIDTH-COEFF_WIDTH){1'b0}}, result_i[i]};
        end
    end

endmodule

`default_nettype wire

// File: rtl/pwo_lane.sv
/*
 * Modular arithmetic lane
 * Stage 1 forms a*b+c, a+b or a-b+Q, stage 2 reduces modulo the ML-DSA prime
 */

`timescale 1ns/1ps
`default_nettype none

module pwo_lane
    import pwo_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  coeff_t a_i,
    input  coeff_t b_i,
    input  coeff_t c_i,
    input  logic   mul_mode_i,
    input  logic   sub_mode_i,
    output coeff_t result_o
);

    logic [2*COEFF_WIDTH-1:0] stage1_d;
    logic [2*COEFF_WIDTH-1:0] stage1_q;
    coeff_t                   result_q;

    // Folding uses 2^23 = 2^13 - 1 mod Q, so each pass trades
    // the high part h for (h << 13) - h, which is never negative
    function automatic coeff_t reduce_q(input logic [2*COEFF_WIDTH-1:0] x);
        logic [36:0] r1;
        logic [27:0] r2;
        logic [23:0] r3;
        r1 = 37'(x[COEFF_WIDTH-1:0]) + (37'(x[2*COEFF_WIDTH-1:COEFF_WIDTH]) << 13)
             - 37'(x[2*COEFF_WIDTH-1:COEFF_WIDTH]);
        r2 = 28'(r1[COEFF_WIDTH-1:0]) + (28'(r1[36:COEFF_WIDTH]) << 13)
             - 28'(r1[36:COEFF_WIDTH]);
        r3 = 24'(r2[COEFF_WIDTH-1:0]) + (24'(r2[27:COEFF_WIDTH]) << 13)
             - 24'(r2[27:COEFF_WIDTH]);
        // r3 is below 2Q here
        if (r3 >= 24'(PWO_Q)) begin
            reduce_q = COEFF_WIDTH'(r3 - 24'(PWO_Q));
        end else begin
            reduce_q = COEFF_WIDTH'(r3);
        end
    endfunction

    always_comb begin
        if (mul_mode_i) begin
            stage1_d = (2*COEFF_WIDTH)'(a_i) * (2*COEFF_WIDTH)'(b_i)
                       + (2*COEFF_WIDTH)'(c_i);
        end else if (sub_mode_i) begin
            // Adding Q keeps the difference positive
            stage1_d = (2*COEFF_WIDTH)'(a_i) - (2*COEFF_WIDTH)'(b_i)
                       + (2*COEFF_WIDTH)'(PWO_Q);
        end else begin
            stage1_d = (2*COEFF_WIDTH)'(a_i) + (2*COEFF_WIDTH)'(b_i);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stage1_q <= '0;
            result_q <= '0;
        end else begin
            stage1_q <= stage1_d;
            result_q <= reduce_q(stage1_q);
        end
    end

    assign result_o = result_q;

endmodule

`default_nettype wire

// File: rtl/pwo_operand_unpack.sv
/*
 * Operand unpacker
 * Aligns the issue tags with the memory read data, registers the words
 * and splits them into per-lane coefficients with decoded mode flags
 */

`timescale 1ns/1ps
`default_nettype none

module pwo_operand_unpack
    import pwo_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             issue_i,
    input  logic                             issue_last_i,
    input  mem_addr_t                        issue_addr_i,
    input  pwo_mode_e                        mode_i,
    input  logic                             accumulate_i,
    input  mem_word_t                        rd_data_a_i,
    input  mem_word_t                        rd_data_b_i,
    input  mem_word_t                        rd_data_c_i,
    output coeff_t [COEFFS_PER_WORD-1:0]     coeff_a_o,
    output coeff_t [COEFFS_PER_WORD-1:0]     coeff_b_o,
    output coeff_t [COEFFS_PER_WORD-1:0]     coeff_c_o,
    output logic                             mul_mode_o,
    output logic                             sub_mode_o,
    output logic                             op_valid_o,
    output logic                             op_last_o,
    output mem_addr_t                        op_addr_o
);

    logic      valid_d [SRAM_LATENCY];
    logic      last_d  [SRAM_LATENCY];
    mem_addr_t addr_d  [SRAM_LATENCY];
    logic      c_sel;

    // Without accumulate the c operand is zero
    assign c_sel = (mode_i == PWO_MUL) && accumulate_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < SRAM_LATENCY; i++) begin
                valid_d[i] <= 1'b0;
                last_d[i]  <= 1'b0;
            end
            op_valid_o <= 1'b0;
            op_last_o  <= 1'b0;
            mul_mode_o <= 1'b0;
            sub_mode_o <= 1'b0;
        end else begin
            // Tag delay matches the memory read latency
            valid_d[0] <= issue_i;
            last_d[0]  <= issue_last_i;
            for (int i = 1; i < SRAM_LATENCY; i++) begin
                valid_d[i] <= valid_d[i-1];
                last_d[i]  <= last_d[i-1];
            end
            op_valid_o <= valid_d[SRAM_LATENCY-1];
            op_last_o  <= last_d[SRAM_LATENCY-1];
            mul_mode_o <= (mode_i == PWO_MUL);
            sub_mode_o <= (mode_i == PWO_SUB);
        end
    end

    always_ff @(posedge clk) begin
        addr_d[0] <= issue_addr_i;
        for (int i = 1; i < SRAM_LATENCY; i++) begin
            addr_d[i] <= addr_d[i-1];
        end
        op_addr_o <= addr_d[SRAM_LATENCY-1];

        // Lane 0 sits in the low slot, pad bit dropped
        for (int i = 0; i < COEFFS_PER_WORD; i++) begin
            coeff_a_o[i] <= rd_data_a_i[i*SLOT_WIDTH +: COEFF_WIDTH];
            coeff_b_o[i] <= rd_data_b_i[i*SLOT_WIDTH +: COEFF_WIDTH];
            coeff_c_o[i] <= c_sel ? rd_data_c_i[i*SLOT_WIDTH +: COEFF_WIDTH] : '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/pwo_addr_gen.sv
/*
 * Read address generator
 * Walks the 64 word indices after a start strobe, issues one read per cycle
 * to the operand memories and tracks busy until the final write completes
 */

`timescale 1ns/1ps
`default_nettype none

module pwo_addr_gen
    import pwo_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      start_i,
    input  pwo_mode_e mode_i,
    input  logic      accumulate_i,
    input  mem_addr_t base_a_i,
    input  mem_addr_t base_b_i,
    input  mem_addr_t base_c_i,
    output logic      rd_en_a_o,
    output logic      rd_en_b_o,
    output logic      rd_en_c_o,
    output mem_addr_t rd_addr_a_o,
    output mem_addr_t rd_addr_b_o,
    output mem_addr_t rd_addr_c_o,
    output logic      issue_o,
    output logic      issue_last_o,
    output mem_addr_t issue_addr_o,
    output logic      busy_o,
    input  logic      done_i
);

    addr_gen_state_e state_q;
    word_idx_t       idx_q;
    logic            busy_q;
    logic            rd_en_q;
    logic            rd_en_c_q;
    logic            last_q;
    mem_addr_t       addr_a_q;
    mem_addr_t       addr_b_q;
    mem_addr_t       addr_c_q;
    logic            launch;
    logic            issue_now;
    logic            idx_at_end;

    // A start is only taken when nothing is in flight
    assign launch     = start_i && !busy_q;
    assign issue_now  = (state_q == RUN) || launch;
    assign idx_at_end = (idx_q == word_idx_t'(POLY_WORDS - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= IDLE;
            idx_q     <= '0;
            busy_q    <= 1'b0;
            rd_en_q   <= 1'b0;
            rd_en_c_q <= 1'b0;
            last_q    <= 1'b0;
            addr_a_q  <= '0;
            addr_b_q  <= '0;
            addr_c_q  <= '0;
        end else begin
            rd_en_q   <= issue_now;
            // Accumulator memory is read only for multiply-accumulate
            rd_en_c_q <= issue_now && (mode_i == PWO_MUL) && accumulate_i;
            last_q    <= issue_now && idx_at_end;

            if (issue_now) begin
                addr_a_q <= base_a_i + mem_addr_t'(idx_q);
                addr_b_q <= base_b_i + mem_addr_t'(idx_q);
                addr_c_q <= base_c_i + mem_addr_t'(idx_q);
                // Wraps back to zero after the last word
                idx_q    <= idx_q + 1'b1;
            end

            case (state_q)
                IDLE:    if (launch) state_q <= RUN;
                RUN:     if (idx_at_end) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase

            if (launch) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign rd_en_a_o    = rd_en_q;
    assign rd_en_b_o    = rd_en_q;
    assign rd_en_c_o    = rd_en_c_q;
    assign rd_addr_a_o  = addr_a_q;
    assign rd_addr_b_o  = addr_b_q;
    assign rd_addr_c_o  = addr_c_q;
    // Results go back to the accumulator word that was read
    assign issue_o      = rd_en_q;
    assign issue_last_o = last_q;
    assign issue_addr_o = addr_c_q;
    assign busy_o       = busy_q;

endmodule

`default_nettype wire

// File: rtl/pwo_pkg.sv
/*
 * Pointwise operation engine shared definitions
 * Widths, the ML-DSA modulus, memory word layout, pipeline latencies
 * and the enumerations used by the control logic
 */

`default_nettype none

package pwo_pkg;

    // ======================================================================
    // Arithmetic and memory layout
    // ======================================================================

    localparam int COEFF_WIDTH     = 23;
    // One zero pad bit above each coefficient in memory
    localparam int SLOT_WIDTH      = 24;
    localparam int COEFFS_PER_WORD = 4;
    localparam int POLY_WORDS      = 64;
    localparam int ADDR_WIDTH      = 15;
    localparam int MEM_DATA_WIDTH  = COEFFS_PER_WORD * SLOT_WIDTH;

    // ML-DSA prime, 2^23 - 2^13 + 1
    localparam logic [COEFF_WIDTH-1:0] PWO_Q = 23'd8380417;

    // Cycles from read strobe to read data
    localparam int SRAM_LATENCY = 1;
    // Register stages inside one arithmetic lane
    localparam int LANE_LATENCY = 2;

    // ======================================================================
    // Types
    // ======================================================================

    typedef logic [COEFF_WIDTH-1:0]        coeff_t;
    typedef logic [ADDR_WIDTH-1:0]         mem_addr_t;
    typedef logic [MEM_DATA_WIDTH-1:0]     mem_word_t;
    typedef logic [$clog2(POLY_WORDS)-1:0] word_idx_t;

    typedef enum logic [1:0] {
        PWO_MUL = 2'd0,
        PWO_ADD = 2'd1,
        PWO_SUB = 2'd2
    } pwo_mode_e;

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } addr_gen_state_e;

endpackage

`default_nettype wire
